//--- logic/ooo_pkg.sv
// shared sizing and payload types for the rename / retire core
package ooo_pkg;

  localparam int XLEN       = 32;                 // register data width
  localparam int NUM_REGS   = 32;                 // architectural registers x0..x31
  localparam int REG_ADDR_W = $clog2(NUM_REGS);   // 5 bit register index
  localparam int ROB_DEPTH  = 8;                  // reorder buffer slots
  localparam int ROB_IX_W   = $clog2(ROB_DEPTH);  // 3 bit rob tag

  // one issued instruction, 16 bits
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;        // destination register
    logic                  writes_rd; // instruction produces a register result
    logic [REG_ADDR_W-1:0] rs1;       // first source
    logic [REG_ADDR_W-1:0] rs2;       // second source
  } issue_req_t;

  // one result reported by an execution unit, 36 bits
  typedef struct packed {
    logic                valid; // single cycle strobe
    logic [ROB_IX_W-1:0] tag;   // rob entry being completed
    logic [XLEN-1:0]     value; // computed result
  } wb_t;

  // head of the rob as it retires, 42 bits
  typedef struct packed {
    logic                  valid;     // head allocated and done
    logic                  writes_rd; // copied from issue
    logic [REG_ADDR_W-1:0] rd;        // architectural destination
    logic [ROB_IX_W-1:0]   tag;       // slot index of the head
    logic [XLEN-1:0]       value;     // result to write back
  } commit_t;

  // raw register file answer for one source, 36 bits
  typedef struct packed {
    logic [XLEN-1:0]     value; // architectural value
    logic                busy;  // a pending writer exists
    logic [ROB_IX_W-1:0] tag;   // youngest pending writer
  } rf_read_t;

  // resolved source operand, 36 bits
  typedef struct packed {
    logic                ready; // value can be used now
    logic [XLEN-1:0]     value; // valid only with ready
    logic [ROB_IX_W-1:0] tag;   // entry to wait on when not ready
  } operand_t;

  // destinations held in each rob slot, slot 0 in the low bits, 40 bits
  // a slot that is free or writes nothing reports x0
  typedef logic [ROB_DEPTH-1:0][REG_ADDR_W-1:0] flush_dests_t;

endpackage

//--- logic/operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

// turns one register file answer into a ready value or a tag to wait on
module operand_resolve (
  input  ooo_pkg::rf_read_t            rf_read,   // value, busy, tag from the regfile
  input  logic                         rob_done,  // rob entry for look_tag has a result
  input  logic [ooo_pkg::XLEN-1:0]     rob_value, // that result
  output logic [ooo_pkg::ROB_IX_W-1:0] look_tag,  // rob slot to look up
  output ooo_pkg::operand_t            operand    // resolved source
);

  assign look_tag = rf_read.tag; // pending writer, only meaningful when busy

  always_comb begin
    operand.tag = rf_read.tag; // consumers watch this when not ready
    if (!rf_read.busy) begin
      operand.ready = 1'b1; // committed value is current
      operand.value = rf_read.value;
    end else if (rob_done) begin
      operand.ready = 1'b1; // bypass result sitting in the rob
      operand.value = rob_value;
    end else begin
      operand.ready = 1'b0; // still executing
      operand.value = rf_read.value; // stale, ignored by consumers
    end
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

// architectural register file with per register busy bit and rename tag
module register_file (
  input  logic                           clk_in,
  input  logic                           rst_in,
  input  logic                           issue_valid, // new instruction this cycle
  input  ooo_pkg::issue_req_t            issue,       // its destination and sources
  input  logic [ooo_pkg::ROB_IX_W-1:0]   alloc_tag,   // rob slot handed to it
  input  ooo_pkg::commit_t               commit,      // retiring rob head
  input  logic                           flush,       // discard everything in flight
  input  ooo_pkg::flush_dests_t          flush_dests, // registers the rob may still own
  output ooo_pkg::rf_read_t              src1_read,   // answer for issue.rs1
  output ooo_pkg::rf_read_t              src2_read    // answer for issue.rs2
);

  logic [ooo_pkg::XLEN-1:0]     regs [ooo_pkg::NUM_REGS]; // committed values
  logic [ooo_pkg::ROB_IX_W-1:0] tags [ooo_pkg::NUM_REGS]; // youngest writer per reg
  logic [ooo_pkg::NUM_REGS-1:0] busy;                     // set while a writer is in flight

  logic retire_we; // commit carries a real register write
  logic issue_we;  // issue claims a real register

  assign retire_we = commit.valid && commit.writes_rd && (commit.rd != '0); // x0 stays zero
  assign issue_we  = issue_valid && issue.writes_rd && (issue.rd != '0);    // x0 never renamed

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
      busy <= '0;
    end else if (flush) begin
      // wipe pending state, values keep their last retired contents
      for (int j = 0; j < ooo_pkg::ROB_DEPTH; j++) begin
        busy[flush_dests[j]] <= 1'b0; // free slots report x0, harmless
      end
    end else begin
      if (retire_we) begin
        regs[commit.rd] <= commit.value;
        if (tags[commit.rd] == commit.tag) begin
          busy[commit.rd] <= 1'b0; // only when no younger writer took the reg
        end
      end
      // issue comes after retire so a same cycle rename keeps busy and its tag
      if (issue_we) begin
        busy[issue.rd] <= 1'b1;
        tags[issue.rd] <= alloc_tag;
      end
    end
  end

  // combinational read ports, see the state left by the previous edge
  always_comb begin
    src1_read.value = regs[issue.rs1];
    src1_read.busy  = busy[issue.rs1];
    src1_read.tag   = tags[issue.rs1];
    src2_read.value = regs[issue.rs2];
    src2_read.busy  = busy[issue.rs2];
    src2_read.tag   = tags[issue.rs2];
  end

  // x0 is hardwired and must never wait on the rob
  a_x0_never_busy : assert property (
    @(posedge clk_in) disable iff (rst_in)
    !busy[0]
  ) else $error("register_file: x0 marked busy");

  // the rob must name every pending destination, otherwise a flush leaves a stale busy
  a_flush_clears_all : assert property (
    @(posedge clk_in) disable iff (rst_in)
    flush |=> (busy == '0)
  ) else $error("register_file: busy bits left after flush, busy=%h", busy);

endmodule

`default_nettype wire

//--- logic/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

// rename and retire core, regfile + rob + two operand resolvers
module rename_core (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         issue_valid, // keep low while rob_full
  input  ooo_pkg::issue_req_t          issue,
  input  ooo_pkg::wb_t                 wb,          // at most one per cycle
  input  logic                         flush,       // single cycle strobe
  output logic [ooo_pkg::ROB_IX_W-1:0] issue_tag,   // rob slot for this issue
  output logic                         rob_full,
  output ooo_pkg::operand_t            src1,
  output ooo_pkg::operand_t            src2,
  output ooo_pkg::commit_t             commit       // retiring entry
);

  ooo_pkg::flush_dests_t        flush_dests; // rob -> regfile on flush
  ooo_pkg::rf_read_t            src1_read;   // raw regfile answers
  ooo_pkg::rf_read_t            src2_read;
  logic [ooo_pkg::ROB_IX_W-1:0] look1_tag;   // resolver -> rob lookups
  logic [ooo_pkg::ROB_IX_W-1:0] look2_tag;
  logic                         look1_done;
  logic                         look2_done;
  logic [ooo_pkg::XLEN-1:0]     look1_value;
  logic [ooo_pkg::XLEN-1:0]     look2_value;

  register_file rf_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue       (issue),
    .alloc_tag   (issue_tag),  // rob tail goes straight to the rename table
    .commit      (commit),
    .flush       (flush),
    .flush_dests (flush_dests),
    .src1_read   (src1_read),
    .src2_read   (src2_read)
  );

  reorder_buffer rob_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue       (issue),
    .wb          (wb),
    .flush       (flush),
    .alloc_tag   (issue_tag),
    .rob_full    (rob_full),
    .commit      (commit),
    .flush_dests (flush_dests),
    .look1_tag   (look1_tag),
    .look2_tag   (look2_tag),
    .look1_done  (look1_done),
    .look2_done  (look2_done),
    .look1_value (look1_value),
    .look2_value (look2_value)
  );

  operand_resolve res1_i (
    .rf_read   (src1_read),
    .rob_done  (look1_done),
    .rob_value (look1_value),
    .look_tag  (look1_tag),
    .operand   (src1)
  );

  operand_resolve res2_i (
    .rf_read   (src2_read),
    .rob_done  (look2_done),
    .rob_value (look2_value),
    .look_tag  (look2_tag),
    .operand   (src2)
  );

endmodule

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// eight entry circular reorder buffer where the tag is the slot index
module reorder_buffer (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         issue_valid, // allocate at tail
  input  ooo_pkg::issue_req_t          issue,       // destination info to keep
  input  ooo_pkg::wb_t                 wb,          // result from execution
  input  logic                         flush,       // empty the queue
  output logic [ooo_pkg::ROB_IX_W-1:0] alloc_tag,   // tag for the current issue
  output logic                         rob_full,    // all slots allocated
  output ooo_pkg::commit_t             commit,      // head entry when done
  output ooo_pkg::flush_dests_t        flush_dests, // per slot pending destination
  input  logic [ooo_pkg::ROB_IX_W-1:0] look1_tag,   // lookup for source 1
  input  logic [ooo_pkg::ROB_IX_W-1:0] look2_tag,   // lookup for source 2
  output logic                         look1_done,
  output logic                         look2_done,
  output logic [ooo_pkg::XLEN-1:0]     look1_value,
  output logic [ooo_pkg::XLEN-1:0]     look2_value
);

  logic [ooo_pkg::ROB_IX_W-1:0] head;  // oldest entry
  logic [ooo_pkg::ROB_IX_W-1:0] tail;  // next slot to allocate
  logic [ooo_pkg::ROB_IX_W:0]   count; // 0..8 entries in flight

  logic [ooo_pkg::ROB_DEPTH-1:0] alloc_q;  // slot holds a live instruction
  logic [ooo_pkg::ROB_DEPTH-1:0] done_q;   // result has arrived
  logic [ooo_pkg::ROB_DEPTH-1:0] writes_q; // instruction writes a register
  logic [ooo_pkg::REG_ADDR_W-1:0] dest_q  [ooo_pkg::ROB_DEPTH]; // destination reg
  logic [ooo_pkg::XLEN-1:0]       value_q [ooo_pkg::ROB_DEPTH]; // stored result

  assign alloc_tag = tail;
  assign rob_full  = (count == ooo_pkg::ROB_DEPTH);

  // head presented as soon as it is complete
  always_comb begin
    commit.valid     = alloc_q[head] && done_q[head];
    commit.writes_rd = writes_q[head];
    commit.rd        = dest_q[head];
    commit.tag       = head;
    commit.value     = value_q[head];
  end

  // result lookup for the operand bypass
  assign look1_done  = alloc_q[look1_tag] && done_q[look1_tag];
  assign look2_done  = alloc_q[look2_tag] && done_q[look2_tag];
  assign look1_value = value_q[look1_tag];
  assign look2_value = value_q[look2_tag];

  // only live writers can hold a busy register and everything else reports x0
  always_comb begin
    for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
      flush_dests[i] = (alloc_q[i] && writes_q[i]) ? dest_q[i] : '0;
    end
  end

  // control state
  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      head    <= '0;
      tail    <= '0; // next tag after reset or flush is 0
      count   <= '0;
      alloc_q <= '0;
      done_q  <= '0;
    end else begin
      if (issue_valid) begin
        alloc_q[tail] <= 1'b1;
        done_q[tail]  <= 1'b0; // clear leftover from the previous use of the slot
        tail          <= tail + 1'b1;
      end
      if (wb.valid) begin
        done_q[wb.tag] <= 1'b1;
      end
      if (commit.valid) begin
        alloc_q[head] <= 1'b0; // pop one per cycle
        head          <= head + 1'b1;
      end
      case ({issue_valid, commit.valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none or both
      endcase
    end
  end

  // payload written at issue and at writeback
  always_ff @(posedge clk_in) begin
    if (issue_valid) begin
      dest_q[tail]   <= issue.rd;
      writes_q[tail] <= issue.writes_rd;
    end
    if (wb.valid) begin
      value_q[wb.tag] <= wb.value;
    end
  end

  // outside must respect back pressure
  a_no_issue_when_full : assert property (
    @(posedge clk_in) disable iff (rst_in)
    issue_valid |-> !rob_full
  ) else $error("reorder_buffer: issue while full, count=%0d", count);

  // an execution unit reports once and only for something in flight
  a_wb_to_live_entry : assert property (
    @(posedge clk_in) disable iff (rst_in)
    (wb.valid && !flush) |-> (alloc_q[wb.tag] && !done_q[wb.tag])
  ) else $error("reorder_buffer: bad writeback tag=%h", wb.tag);

  // occupancy bound plus agreement between the counter and the slot flags
  a_count_bound : assert property (
    @(posedge clk_in) disable iff (rst_in)
    (count <= ooo_pkg::ROB_DEPTH) && ($countones(alloc_q) == count)
  ) else $error("reorder_buffer: count=%0d alloc=%h", count, alloc_q);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rename core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module rename_core_tb \
  -f vlog.f \
  -o rename_core_sim

./obj_dir/rename_core_sim 2>&1 | tee "$LOG"

if grep -q "STATUS: PASS" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

//--- verif/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;

  localparam int PLANNED_CYCLES = 190;                // reset plus the six tests
  localparam int TIMEOUT_CYCLES = 5 * PLANNED_CYCLES; // hard stop

  logic                         clk_in;
  logic                         rst_in;
  logic                         issue_valid;
  ooo_pkg::issue_req_t          issue;
  ooo_pkg::wb_t                 wb;
  logic                         flush;
  logic [ooo_pkg::ROB_IX_W-1:0] issue_tag;
  logic                         rob_full;
  ooo_pkg::operand_t            src1;
  ooo_pkg::operand_t            src2;
  ooo_pkg::commit_t             commit;

  int seed;         // $random state
  int errors;       // failed checks over the run
  int checks;       // all checks over the run
  int test_checks0; // counters at the start of the current test
  int test_errors0;
  int cycles;       // clock edges since time zero

  // reference model of the architectural state and the rob queue
  logic [ooo_pkg::XLEN-1:0]       m_regs [ooo_pkg::NUM_REGS];
  logic                           m_busy [ooo_pkg::NUM_REGS];
  logic [ooo_pkg::ROB_IX_W-1:0]   m_tags [ooo_pkg::NUM_REGS];
  logic [ooo_pkg::REG_ADDR_W-1:0] q_rd   [ooo_pkg::ROB_DEPTH];
  logic                           q_wr   [ooo_pkg::ROB_DEPTH];
  logic                           q_done [ooo_pkg::ROB_DEPTH];
  logic [ooo_pkg::XLEN-1:0]       q_val  [ooo_pkg::ROB_DEPTH];
  logic [ooo_pkg::ROB_IX_W-1:0]   m_head;
  logic [ooo_pkg::ROB_IX_W-1:0]   m_tail;
  int                             m_count;

  rename_core dut_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue       (issue),
    .wb          (wb),
    .flush       (flush),
    .issue_tag   (issue_tag),
    .rob_full    (rob_full),
    .src1        (src1),
    .src2        (src2),
    .commit      (commit)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in; // 20 ns period
  end

  // watchdog that ends a hung run
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic is_live(input int s);
    logic [ooo_pkg::ROB_IX_W-1:0] off;
    off = ooo_pkg::ROB_IX_W'(s) - m_head; // distance from the oldest entry
    return int'(off) < m_count;
  endfunction

  function automatic ooo_pkg::issue_req_t make_req(input int src_span);
    ooo_pkg::issue_req_t req;
    req.rd        = 5'(rand_below(8)); // small range so renames collide and x0 shows up
    req.writes_rd = (rand_below(4) != 0);
    req.rs1       = 5'(rand_below(src_span));
    req.rs2       = 5'(rand_below(src_span));
    return req;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  // expected operand straight from the rename rules
  task automatic check_operand(input string name, input ooo_pkg::operand_t got,
                               input logic [ooo_pkg::REG_ADDR_W-1:0] r);
    logic [ooo_pkg::ROB_IX_W-1:0] t;
    t = m_tags[r];
    if (!m_busy[r]) begin
      check_field({name, ".ready"}, 32'(got.ready), 32'd1);
      check_field({name, ".value"}, got.value, m_regs[r]);
    end else if (q_done[t]) begin
      check_field({name, ".ready"}, 32'(got.ready), 32'd1); // bypass from the rob
      check_field({name, ".value"}, got.value, q_val[t]);
    end else begin
      check_field({name, ".ready"}, 32'(got.ready), 32'd0);
      check_field({name, ".tag"}, 32'(got.tag), 32'(t)); // youngest writer
    end
  endtask

  task automatic check_outputs(input ooo_pkg::issue_req_t req);
    logic cv;
    cv = (m_count > 0) && q_done[m_head];
    check_field("issue_tag", 32'(issue_tag), 32'(m_tail));
    check_field("rob_full", 32'(rob_full), 32'(m_count == ooo_pkg::ROB_DEPTH));
    check_field("commit.valid", 32'(commit.valid), 32'(cv));
    if (cv) begin
      check_field("commit.tag", 32'(commit.tag), 32'(m_head)); // program order
      check_field("commit.writes_rd", 32'(commit.writes_rd), 32'(q_wr[m_head]));
      check_field("commit.rd", 32'(commit.rd), 32'(q_rd[m_head]));
      check_field("commit.value", commit.value, q_val[m_head]);
    end
    check_operand("src1", src1, req.rs1);
    check_operand("src2", src2, req.rs2);
  endtask

  // effect of the coming rising edge in the order flush, retire, writeback, issue
  task automatic update_model(input logic iv, input ooo_pkg::issue_req_t req,
                              input ooo_pkg::wb_t w, input logic fl);
    logic cv;
    cv = (m_count > 0) && q_done[m_head];
    if (fl) begin
      for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
        m_busy[r] = 1'b0; // nothing stays pending
      end
      m_head  = '0;
      m_tail  = '0;
      m_count = 0;
    end else begin
      if (cv) begin
        if (q_wr[m_head] && q_rd[m_head] != '0) begin
          m_regs[q_rd[m_head]] = q_val[m_head];
          if (m_tags[q_rd[m_head]] == m_head) begin
            m_busy[q_rd[m_head]] = 1'b0; // a younger writer keeps it busy
          end
        end
        m_head++;
        m_count--;
      end
      if (w.valid) begin
        q_done[w.tag] = 1'b1;
        q_val[w.tag]  = w.value;
      end
      if (iv) begin
        q_rd[m_tail]   = req.rd;
        q_wr[m_tail]   = req.writes_rd;
        q_done[m_tail] = 1'b0;
        if (req.writes_rd && req.rd != '0) begin
          m_busy[req.rd] = 1'b1; // issue wins over a same cycle retire
          m_tags[req.rd] = m_tail;
        end
        m_tail++;
        m_count++;
      end
    end
  endtask

  task automatic drive_cycle(input logic iv, input ooo_pkg::issue_req_t req,
                             input ooo_pkg::wb_t w, input logic fl);
    @(posedge clk_in);
    issue_valid <= iv;
    issue       <= req;
    wb          <= w;
    flush       <= fl;
    @(negedge clk_in); // outputs settled mid cycle
    check_outputs(req);
    update_model(iv, req, w, fl);
  endtask

  // random issue and writeback that never issues into a full rob
  task automatic random_cycle(input int p_issue, input int p_wb);
    ooo_pkg::issue_req_t req;
    ooo_pkg::wb_t        w;
    logic                iv;
    int                  cand[$];
    req = make_req(8);
    iv  = (m_count < ooo_pkg::ROB_DEPTH) && (rand_below(100) < p_issue);
    w   = '0;
    for (int s = 0; s < ooo_pkg::ROB_DEPTH; s++) begin
      if (is_live(s) && !q_done[s]) cand.push_back(s);
    end
    if (cand.size() > 0 && rand_below(100) < p_wb) begin
      w.valid = 1'b1;
      w.tag   = ooo_pkg::ROB_IX_W'(cand[rand_below(cand.size())]);
      w.value = $random(seed);
    end
    drive_cycle(iv, req, w, 1'b0);
  endtask

  task automatic start_test();
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - test_checks0, errors - test_errors0);
  endtask

  initial begin
    ooo_pkg::issue_req_t req;
    ooo_pkg::wb_t        w;
    seed        = 32'hbe8c_f81b;
    errors      = 0;
    checks      = 0;
    rst_in      = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    wb          = '0;
    flush       = 1'b0;
    for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
      m_regs[r] = '0;
      m_busy[r] = 1'b0;
      m_tags[r] = '0;
    end
    for (int s = 0; s < ooo_pkg::ROB_DEPTH; s++) begin
      q_done[s] = 1'b0;
    end
    m_head  = '0;
    m_tail  = '0;
    m_count = 0;
    repeat (10) @(posedge clk_in);
    rst_in <= 1'b0;

    start_test(); // every register reads zero and ready
    for (int k = 0; k < 16; k++) begin
      req     = '0;
      req.rs1 = 5'(2 * k);
      req.rs2 = 5'(2 * k + 1);
      drive_cycle(1'b0, req, '0, 1'b0);
    end
    end_test(1, "reset_state");

    start_test();
    repeat (12) random_cycle(70, 0);
    end_test(2, "random_issue");

    start_test();
    repeat (60) random_cycle(60, 50);
    end_test(3, "random_writeback");

    start_test(); // drain until the model rob is empty
    while (m_count > 0) random_cycle(0, 70);
    end_test(4, "retire_order");

    start_test();
    repeat (8) random_cycle(100, 0); // empty rob so all eight issue
    random_cycle(0, 0);
    check_field("rob_full", 32'(rob_full), 32'd1);
    w       = '0;
    w.valid = 1'b1;
    w.tag   = m_head;
    w.value = $random(seed);
    drive_cycle(1'b0, make_req(8), w, 1'b0);
    random_cycle(0, 0); // head retires here
    random_cycle(0, 0);
    check_field("rob_full", 32'(rob_full), 32'd0);
    end_test(5, "rob_full");

    start_test();
    if (m_tail == '0) begin
      drive_cycle(1'b1, make_req(8), '0, 1'b0); // tail moves off slot 0 before the flush
    end
    w       = '0;
    w.valid = 1'b1;
    w.tag   = m_head + 3'd2; // younger entries done while the head still blocks retire
    w.value = $random(seed);
    drive_cycle(1'b0, make_req(8), w, 1'b0);
    w.tag   = m_head + 3'd4;
    w.value = $random(seed);
    drive_cycle(1'b0, make_req(8), w, 1'b0);
    drive_cycle(1'b0, make_req(8), '0, 1'b1);
    for (int k = 0; k < 16; k++) begin
      req     = '0;
      req.rs1 = 5'(2 * k);
      req.rs2 = 5'(2 * k + 1);
      drive_cycle(1'b0, req, '0, 1'b0);
      if (k == 0) check_field("issue_tag", 32'(issue_tag), 32'd0);
    end
    end_test(6, "flush");

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/ooo_pkg.sv
logic/register_file.sv
logic/reorder_buffer.sv
logic/operand_resolve.sv
logic/rename_core.sv
verif/rename_core_tb.sv
